// ==== issueStage_testdata.txt ====
// test v0 v1 instr src1 src2 dst alu imm flags drop dep full ocFull | expected
// ocValid ocWarpId ocInstr ocDst exitValid exitWarpId fetchReq, one cycle per line
1_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_0_0_00000000_00_0_0_f
2_4_0_a0000002_01_02_03_1_0012_340_0_0_0_0_0_0_00000000_00_0_0_f
2_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_2_a0000002_03_0_0_b
2_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_0_0_00000000_00_0_0_f
3_2_2_b0000001_04_05_06_7_0000_240_0_0_0_0_0_0_00000000_00_0_0_f
3_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_1_b0000001_06_0_0_d
3_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_1_b0000001_07_0_0_d
3_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_0_0_00000000_00_0_0_f
4_8_0_c0000000_08_09_0a_4_00ff_2c0_0_0_0_0_0_0_00000000_00_0_0_f
4_0_0_00000000_00_00_00_0_0000_000_0_8_0_0_0_0_00000000_00_0_0_7
4_0_0_00000000_00_00_00_0_0000_000_0_0_8_0_0_0_00000000_00_0_0_7
4_0_0_00000000_00_00_00_0_0000_000_0_0_0_1_0_0_00000000_00_0_0_7
4_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_3_c0000000_0a_0_0_7
5_b_1_d0000000_0b_0c_10_2_0005_340_0_0_0_0_0_0_00000000_00_0_0_f
5_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_0_d0000000_10_0_0_4
5_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_1_d0000000_10_0_0_4
5_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_3_d0000000_10_0_0_6
5_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_1_0_d0000000_11_0_0_e
5_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_0_0_00000000_00_0_0_f
6_4_0_e0000002_0d_0e_12_3_0000_340_0_0_0_0_0_0_00000000_00_0_0_f
6_2_0_f0000001_00_00_00_0_0000_001_4_0_0_1_0_0_00000000_00_0_0_b
6_0_0_00000000_00_00_00_0_0000_000_0_0_0_1_0_0_00000000_00_1_1_d
6_0_0_00000000_00_00_00_0_0000_000_0_0_0_0_0_0_00000000_00_0_0_f

// ==== issueStage.f ====
instrBufferPkg.sv
warpInstrBuffer.sv
issueArbiter.sv
instrBuffer.sv
issueStage.sv
issueStage_assertions.sv
tb_issueStage.sv

// ==== runSim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_issueStage \
    -f issueStage.f -o simIssueStage &&
simOut="$(./obj_dir/simIssueStage)" ;
echo "$simOut" ;
echo "$simOut" | grep -q "Result: PASSED" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// ==== tb_issueStage.sv ====
`timescale 1ns/1ps

module tb_issueStage;
    import instrBufferPkg::*;

    localparam int numWarps = 4;
    localparam int numThreads = 8;
    localparam int warpIdW = $clog2(numWarps);
    localparam int stepW = 176;
    localparam int maxSteps = 64;
    localparam int resetCycles = 16;
    localparam int clkPeriod = 8;

    logic clk;
    logic arstN;
    logic [numWarps-1:0] decValid0, decValid1;
    logic [instrW-1:0] dec0Instr, dec1Instr;
    logic [regIdW-1:0] dec0Src1, dec0Src2, dec0Dst, dec1Src1, dec1Src2, dec1Dst;
    logic dec0Src1Valid, dec0Src2Valid, dec0ImmValid, dec0RegWrite, dec0MemWrite;
    logic dec0MemRead, dec0Shared, dec0Beq, dec0Blt, dec0Exit;
    logic dec1Src1Valid, dec1Src2Valid, dec1ImmValid, dec1RegWrite, dec1MemWrite;
    logic dec1MemRead, dec1Shared, dec1Beq, dec1Blt, dec1Exit;
    aluOpE dec0AluOp, dec1AluOp;
    logic [immW-1:0] dec0Imm, dec1Imm;
    logic [numWarps-1:0] dropInstr, scbFull, scbDependent;
    logic [numWarps*numThreads-1:0] activeMask;
    logic ocFull;
    logic [regIdW*numWarps-1:0] headSrc1, headSrc2, headDst;
    logic [numWarps-1:0] headSrc1Valid, headSrc2Valid, headDstValid;
    logic [numWarps-1:0] fetchReq, issueReq, exitReq;
    logic ocValid;
    logic [warpIdW-1:0] ocWarpId;
    logic [numThreads-1:0] ocActiveMask;
    logic [instrW-1:0] ocInstr;
    logic [regIdW-1:0] ocSrc1, ocSrc2, ocDst;
    logic ocSrc1Valid, ocSrc2Valid, ocImmValid, ocRegWrite, ocMemWrite, ocMemRead;
    logic ocShared, ocBeq, ocBlt;
    aluOpE ocAluOp;
    logic [immW-1:0] ocImm;
    logic exitValid;
    logic [warpIdW-1:0] exitWarpId;

    logic [stepW-1:0] stepMem [maxSteps];
    logic [numThreads-1:0] maskPattern [numWarps];
    // decoded fields by instruction word, for matching the collector outputs
    logic [47:0] fieldsByInstr [logic [31:0]];
    // expected queue contents per warp, head in slot 0
    // entry holds exit, regWrite, src2Valid, src1Valid, src1, src2, dst
    logic [18:0] queueEntry [numWarps][2];
    int queueCount [numWarps];
    int numSteps = 0;
    int curTest = 0;
    int testCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testChecks = 0;
    int testErrors = 0;
    bit loaded = 0;

    issueStage #(
        .numWarps(numWarps),
        .numThreads(numThreads)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic string testName(input int t);
        case (t)
            1: return "resetState";
            2: return "singleDecode";
            3: return "dualDecodeOrder";
            4: return "issueHold";
            5: return "roundRobin";
            6: return "dropAndExit";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        testChecks++;
        assert (expected === actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     testName(curTest), what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    // port 1 reuses the port 0 fields, destination plus one
    task automatic driveStep(input logic [stepW-1:0] s);
        decValid0 = s[171:168];
        decValid1 = s[167:164];
        dec0Instr = s[163:132];
        dec0Src1 = s[128:124];
        dec0Src2 = s[120:116];
        dec0Dst = s[112:108];
        dec0AluOp = aluOpE'(s[107:104]);
        dec0Imm = s[103:88];
        {dec0Src1Valid, dec0Src2Valid, dec0ImmValid, dec0RegWrite, dec0MemWrite,
         dec0MemRead, dec0Shared, dec0Beq, dec0Blt, dec0Exit} = s[85:76];
        dec1Instr = dec0Instr;
        dec1Src1 = dec0Src1;
        dec1Src2 = dec0Src2;
        dec1Dst = dec0Dst + regIdW'(1);
        dec1AluOp = dec0AluOp;
        dec1Imm = dec0Imm;
        {dec1Src1Valid, dec1Src2Valid, dec1ImmValid, dec1RegWrite, dec1MemWrite,
         dec1MemRead, dec1Shared, dec1Beq, dec1Blt, dec1Exit} = s[85:76];
        dropInstr = s[75:72];
        scbDependent = s[71:68];
        scbFull = s[67:64];
        ocFull = s[60];
        if ((s[171:168] | s[167:164]) != '0)
            fieldsByInstr[s[163:132]] = {s[131:116], s[107:76]};
    endtask

    task automatic checkStep(input logic [stepW-1:0] s);
        logic [47:0] actFields;
        logic [31:0] expInstr;
        logic [warpIdW-1:0] expWarp;
        expInstr = s[51:20];
        expWarp = s[52 +: warpIdW];
        checkValue("ocValid", s[56], ocValid);
        checkValue("exitValid", s[8], exitValid);
        checkValue("fetchReq", s[3:0], fetchReq);
        if (s[56]) begin
            checkValue("ocWarpId", expWarp, ocWarpId);
            checkValue("ocInstr", expInstr, ocInstr);
            checkValue("ocDst", s[16:12], ocDst);
            checkValue("ocActiveMask", maskPattern[expWarp], ocActiveMask);
            actFields = {3'b000, ocSrc1, 3'b000, ocSrc2, 4'(ocAluOp), ocImm, 2'b00,
                         ocSrc1Valid, ocSrc2Valid, ocImmValid, ocRegWrite, ocMemWrite,
                         ocMemRead, ocShared, ocBeq, ocBlt, 1'b0};
            assert (fieldsByInstr.exists(expInstr)) begin
                checkValue("ocFields", fieldsByInstr[expInstr], actFields);
            end else begin
                $display("%s: the expected instruction %h was never driven on decode",
                         testName(curTest), expInstr);
                errorCount++;
                testErrors++;
            end
        end
        if (s[8])
            checkValue("exitWarpId", s[4 +: warpIdW], exitWarpId);
    endtask

    // requests and scoreboard fields of each head
    task automatic checkHeads(input logic [stepW-1:0] s);
        logic [numWarps-1:0] expIssueReq;
        logic [numWarps-1:0] expExitReq;
        logic [numWarps-1:0] expSrc1Valid;
        logic [numWarps-1:0] expSrc2Valid;
        logic [numWarps-1:0] expDstValid;
        logic [18:0] head;
        for (int w = 0; w < numWarps; w++) begin
            head = queueEntry[w][0];
            expIssueReq[w] = 1'b0;
            expExitReq[w] = 1'b0;
            expSrc1Valid[w] = 1'b0;
            expSrc2Valid[w] = 1'b0;
            expDstValid[w] = 1'b0;
            if (queueCount[w] > 0) begin
                expIssueReq[w] = !head[18] && !s[68 + w] && !s[64 + w];
                expExitReq[w] = head[18];
                expDstValid[w] = head[17];
                expSrc2Valid[w] = head[16];
                expSrc1Valid[w] = head[15];
                checkValue($sformatf("headSrc1[%0d]", w), head[14:10],
                           headSrc1[regIdW*w +: regIdW]);
                checkValue($sformatf("headSrc2[%0d]", w), head[9:5],
                           headSrc2[regIdW*w +: regIdW]);
                checkValue($sformatf("headDst[%0d]", w), head[4:0],
                           headDst[regIdW*w +: regIdW]);
            end
        end
        checkValue("issueReq", expIssueReq, issueReq);
        checkValue("exitReq", expExitReq, exitReq);
        checkValue("headSrc1Valid", expSrc1Valid, headSrc1Valid);
        checkValue("headSrc2Valid", expSrc2Valid, headSrc2Valid);
        checkValue("headDstValid", expDstValid, headDstValid);
    endtask

    task automatic popQueue(input int w);
        queueEntry[w][0] = queueEntry[w][1];
        if (queueCount[w] > 0)
            queueCount[w]--;
    endtask

    // pops follow the expected grants, then a flush or the decode writes
    task automatic updateQueues(input logic [stepW-1:0] s);
        logic [18:0] entry0;
        logic [18:0] entry1;
        entry0 = {dec0Exit, dec0RegWrite, dec0Src2Valid, dec0Src1Valid,
                  dec0Src1, dec0Src2, dec0Dst};
        entry1 = {dec1Exit, dec1RegWrite, dec1Src2Valid, dec1Src1Valid,
                  dec1Src1, dec1Src2, dec1Dst};
        if (s[56])
            popQueue(s[52 +: warpIdW]);
        if (s[8])
            popQueue(s[4 +: warpIdW]);
        for (int w = 0; w < numWarps; w++) begin
            if (s[72 + w]) begin
                queueCount[w] = 0;
            end else begin
                if (s[168 + w] && queueCount[w] < 2) begin
                    queueEntry[w][queueCount[w]] = entry0;
                    queueCount[w]++;
                end
                if (s[164 + w] && queueCount[w] < 2) begin
                    queueEntry[w][queueCount[w]] = entry1;
                    queueCount[w]++;
                end
            end
        end
    endtask

    task automatic reportTest();
        $display("test %0d %s: %0d checks, %0d errors",
                 curTest, testName(curTest), testChecks, testErrors);
        testCount++;
        testChecks = 0;
        testErrors = 0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        arstN = 1'b0;
        driveStep('0);
        void'($urandom(32'hc652d858));
        for (int w = 0; w < numWarps; w++) begin
            maskPattern[w] = numThreads'($urandom);
            activeMask[numThreads*w +: numThreads] = maskPattern[w];
        end
        foreach (stepMem[i])
            stepMem[i] = '0;
        $readmemh("issueStage_testdata.txt", stepMem);
        // test number zero ends the table
        while (numSteps < maxSteps && stepMem[numSteps][175:172] != 4'h0)
            numSteps++;
        loaded = 1'b1;
        assert (numSteps > 0) else begin
            $display("no test steps were read from the data file");
            errorCount++;
        end

        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        for (int s = 0; s < numSteps; s++) begin
            curTest = stepMem[s][175:172];
            driveStep(stepMem[s]);
            #(clkPeriod - 2);
            checkStep(stepMem[s]);
            checkHeads(stepMem[s]);
            updateQueues(stepMem[s]);
            if (s == numSteps - 1 || stepMem[s + 1][175:172] != stepMem[s][175:172])
                reportTest();
            @(posedge clk);
            #1;
        end

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // twice the length of reset plus all steps
    initial begin
        wait (loaded);
        #((numSteps + resetCycles) * clkPeriod * 2);
        $display("timeout: the test steps did not finish in the expected time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== issueStage_assertions.sv ====
`timescale 1ns/1ps

module issueStage_assertions #(
    parameter int numWarps = 8
) (
    input  logic clk,
    input  logic arstN,
    input  logic [numWarps-1:0] issueReq,
    input  logic [numWarps-1:0] issueGrant,
    input  logic [numWarps-1:0] exitGrant,
    input  logic ocFull
);

    // at most one warp issues, and only a warp that asked
    issueGrantLegal: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(issueGrant) && ((issueGrant & ~issueReq) == '0))
        else $error("issue grant is not one-hot or goes to a warp without a request");

    // full collector blocks every issue
    noIssueWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        ocFull |-> (issueGrant == '0))
        else $error("issue grant given while the operand collector is full");

    exitGrantLegal: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(exitGrant))
        else $error("exit grant is not one-hot");

endmodule

bind issueArbiter issueStage_assertions #(
    .numWarps(numWarps)
) arbiterChecks_i (
    .clk(clk),
    .arstN(arstN),
    .issueReq(issueReq),
    .issueGrant(issueGrant),
    .exitGrant(exitGrant),
    .ocFull(ocFull)
);

// ==== issueStage.sv ====
`timescale 1ns/1ps

module issueStage #(
    parameter int numWarps = 8,
    parameter int numThreads = 8
) (
    input  logic clk,
    input  logic arstN,

    // decode ports
    input  logic [numWarps-1:0] decValid0,
    input  logic [instrBufferPkg::instrW-1:0] dec0Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec0Src1, dec0Src2, dec0Dst,
    input  logic dec0Src1Valid, dec0Src2Valid,
    input  instrBufferPkg::aluOpE dec0AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec0Imm,
    input  logic dec0ImmValid, dec0RegWrite, dec0MemWrite, dec0MemRead,
    input  logic dec0Shared, dec0Beq, dec0Blt, dec0Exit,
    input  logic [numWarps-1:0] decValid1,
    input  logic [instrBufferPkg::instrW-1:0] dec1Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec1Src1, dec1Src2, dec1Dst,
    input  logic dec1Src1Valid, dec1Src2Valid,
    input  instrBufferPkg::aluOpE dec1AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec1Imm,
    input  logic dec1ImmValid, dec1RegWrite, dec1MemWrite, dec1MemRead,
    input  logic dec1Shared, dec1Beq, dec1Blt, dec1Exit,

    // SIMT stack
    input  logic [numWarps-1:0] dropInstr,
    input  logic [numWarps*numThreads-1:0] activeMask,

    // scoreboard
    input  logic [numWarps-1:0] scbFull,
    input  logic [numWarps-1:0] scbDependent,
    output logic [instrBufferPkg::regIdW*numWarps-1:0] headSrc1, headSrc2, headDst,
    output logic [numWarps-1:0] headSrc1Valid, headSrc2Valid, headDstValid,

    // fetch and warp requests
    output logic [numWarps-1:0] fetchReq,
    output logic [numWarps-1:0] issueReq,
    output logic [numWarps-1:0] exitReq,

    // operand collector
    input  logic ocFull,
    output logic ocValid,
    output logic [$clog2(numWarps)-1:0] ocWarpId,
    output logic [numThreads-1:0] ocActiveMask,
    output logic [instrBufferPkg::instrW-1:0] ocInstr,
    output logic [instrBufferPkg::regIdW-1:0] ocSrc1, ocSrc2, ocDst,
    output logic ocSrc1Valid, ocSrc2Valid,
    output instrBufferPkg::aluOpE ocAluOp,
    output logic [instrBufferPkg::immW-1:0] ocImm,
    output logic ocImmValid, ocRegWrite, ocMemWrite, ocMemRead,
    output logic ocShared, ocBeq, ocBlt,

    // resource allocator
    output logic exitValid,
    output logic [$clog2(numWarps)-1:0] exitWarpId
);
    // grants run from the arbiter back into the buffer
    logic [numWarps-1:0] issueGrant;
    logic [numWarps-1:0] exitGrant;

    // every buffer port shares its name with a port or wire here
    instrBuffer #(
        .numWarps(numWarps),
        .numThreads(numThreads)
    ) instrBuffer_i (.*);

    issueArbiter #(
        .numWarps(numWarps)
    ) issueArbiter_i (
        .clk(clk),
        .arstN(arstN),
        .issueReq(issueReq),
        .exitReq(exitReq),
        .ocFull(ocFull),
        .issueGrant(issueGrant),
        .exitGrant(exitGrant)
    );

endmodule

// ==== instrBuffer.sv ====
`timescale 1ns/1ps

module instrBuffer #(
    parameter int numWarps = 8,
    parameter int numThreads = 8
) (
    input  logic clk,
    input  logic arstN,

    // decode ports, valid per warp, fields shared
    input  logic [numWarps-1:0] decValid0,
    input  logic [instrBufferPkg::instrW-1:0] dec0Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec0Src1, dec0Src2, dec0Dst,
    input  logic dec0Src1Valid, dec0Src2Valid,
    input  instrBufferPkg::aluOpE dec0AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec0Imm,
    input  logic dec0ImmValid, dec0RegWrite, dec0MemWrite, dec0MemRead,
    input  logic dec0Shared, dec0Beq, dec0Blt, dec0Exit,
    input  logic [numWarps-1:0] decValid1,
    input  logic [instrBufferPkg::instrW-1:0] dec1Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec1Src1, dec1Src2, dec1Dst,
    input  logic dec1Src1Valid, dec1Src2Valid,
    input  instrBufferPkg::aluOpE dec1AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec1Imm,
    input  logic dec1ImmValid, dec1RegWrite, dec1MemWrite, dec1MemRead,
    input  logic dec1Shared, dec1Beq, dec1Blt, dec1Exit,

    // SIMT stack
    input  logic [numWarps-1:0] dropInstr,
    input  logic [numWarps*numThreads-1:0] activeMask,

    // scoreboard
    input  logic [numWarps-1:0] scbFull,
    input  logic [numWarps-1:0] scbDependent,
    output logic [instrBufferPkg::regIdW*numWarps-1:0] headSrc1, headSrc2, headDst,
    output logic [numWarps-1:0] headSrc1Valid, headSrc2Valid, headDstValid,

    // fetch and arbiter
    output logic [numWarps-1:0] fetchReq,
    output logic [numWarps-1:0] issueReq,
    output logic [numWarps-1:0] exitReq,
    input  logic [numWarps-1:0] issueGrant,
    input  logic [numWarps-1:0] exitGrant,

    // operand collector
    output logic ocValid,
    output logic [$clog2(numWarps)-1:0] ocWarpId,
    output logic [numThreads-1:0] ocActiveMask,
    output logic [instrBufferPkg::instrW-1:0] ocInstr,
    output logic [instrBufferPkg::regIdW-1:0] ocSrc1, ocSrc2, ocDst,
    output logic ocSrc1Valid, ocSrc2Valid,
    output instrBufferPkg::aluOpE ocAluOp,
    output logic [instrBufferPkg::immW-1:0] ocImm,
    output logic ocImmValid, ocRegWrite, ocMemWrite, ocMemRead,
    output logic ocShared, ocBeq, ocBlt,

    // resource allocator
    output logic exitValid,
    output logic [$clog2(numWarps)-1:0] exitWarpId
);
    import instrBufferPkg::*;

    localparam int warpIdW = $clog2(numWarps);

    // head fields per warp that the scoreboard does not see
    logic [instrW-1:0] wInstr [numWarps];
    aluOpE wAluOp [numWarps];
    logic [immW-1:0] wImm [numWarps];
    logic [numWarps-1:0] wImmValid, wMemWrite, wMemRead, wShared, wBeq, wBlt;

    for (genvar i = 0; i < numWarps; i++) begin : warpGen
        warpInstrBuffer warpBuf_i (
            .clk, .arstN,
            .decValid0(decValid0[i]),
            .dec0Instr, .dec0Src1, .dec0Src2, .dec0Dst,
            .dec0Src1Valid, .dec0Src2Valid, .dec0AluOp, .dec0Imm, .dec0ImmValid,
            .dec0RegWrite, .dec0MemWrite, .dec0MemRead,
            .dec0Shared, .dec0Beq, .dec0Blt, .dec0Exit,
            .decValid1(decValid1[i]),
            .dec1Instr, .dec1Src1, .dec1Src2, .dec1Dst,
            .dec1Src1Valid, .dec1Src2Valid, .dec1AluOp, .dec1Imm, .dec1ImmValid,
            .dec1RegWrite, .dec1MemWrite, .dec1MemRead,
            .dec1Shared, .dec1Beq, .dec1Blt, .dec1Exit,
            .dropInstr(dropInstr[i]),
            .scbFull(scbFull[i]),
            .scbDependent(scbDependent[i]),
            .issueGrant(issueGrant[i]),
            .exitGrant(exitGrant[i]),
            .fetchReq(fetchReq[i]),
            .issueReq(issueReq[i]),
            .exitReq(exitReq[i]),
            // register ids go straight into the flattened scoreboard vectors
            .headSrc1(headSrc1[regIdW*i +: regIdW]),
            .headSrc2(headSrc2[regIdW*i +: regIdW]),
            .headDst(headDst[regIdW*i +: regIdW]),
            .headSrc1Valid(headSrc1Valid[i]),
            .headSrc2Valid(headSrc2Valid[i]),
            .headDstValid(headDstValid[i]),
            .headInstr(wInstr[i]),
            .headAluOp(wAluOp[i]),
            .headImm(wImm[i]),
            .headImmValid(wImmValid[i]),
            .headMemWrite(wMemWrite[i]),
            .headMemRead(wMemRead[i]),
            .headShared(wShared[i]),
            .headBeq(wBeq[i]),
            .headBlt(wBlt[i])
        );
    end

    //////////////////////////////
    // collector and exit mux
    //////////////////////////////

    assign ocValid = |issueGrant;
    assign exitValid = |exitGrant;

    always_comb begin
        ocWarpId = '0;
        ocActiveMask = '0;
        ocInstr = '0;
        ocSrc1 = '0;
        ocSrc2 = '0;
        ocDst = '0;
        ocSrc1Valid = 1'b0;
        ocSrc2Valid = 1'b0;
        ocAluOp = aluAdd;
        ocImm = '0;
        ocImmValid = 1'b0;
        ocRegWrite = 1'b0;
        ocMemWrite = 1'b0;
        ocMemRead = 1'b0;
        ocShared = 1'b0;
        ocBeq = 1'b0;
        ocBlt = 1'b0;
        exitWarpId = '0;
        for (int j = 0; j < numWarps; j++) begin
            if (issueGrant[j]) begin
                ocWarpId = warpIdW'(j);
                ocActiveMask = activeMask[numThreads*j +: numThreads];
                ocInstr = wInstr[j];
                ocSrc1 = headSrc1[regIdW*j +: regIdW];
                ocSrc2 = headSrc2[regIdW*j +: regIdW];
                ocDst = headDst[regIdW*j +: regIdW];
                ocSrc1Valid = headSrc1Valid[j];
                ocSrc2Valid = headSrc2Valid[j];
                ocAluOp = wAluOp[j];
                ocImm = wImm[j];
                ocImmValid = wImmValid[j];
                ocRegWrite = headDstValid[j];
                ocMemWrite = wMemWrite[j];
                ocMemRead = wMemRead[j];
                ocShared = wShared[j];
                ocBeq = wBeq[j];
                ocBlt = wBlt[j];
            end
            if (exitGrant[j])
                exitWarpId = warpIdW'(j);
        end
    end

endmodule

// ==== issueArbiter.sv ====
`timescale 1ns/1ps

module issueArbiter #(
    parameter int numWarps = 8
) (
    input  logic clk,
    input  logic arstN,
    input  logic [numWarps-1:0] issueReq,
    input  logic [numWarps-1:0] exitReq,
    input  logic ocFull,
    output logic [numWarps-1:0] issueGrant,
    output logic [numWarps-1:0] exitGrant
);
    localparam int warpIdW = $clog2(numWarps);

    logic [warpIdW-1:0] rrPtr;
    logic [warpIdW-1:0] grantIdx;
    logic rrFound;
    int rrIdx;

    //////////////////////////////
    // round-robin issue grant
    //////////////////////////////

    // first requester at or after the pointer, wrapping around
    always_comb begin
        issueGrant = '0;
        grantIdx = rrPtr;
        rrFound = 1'b0;
        rrIdx = 0;
        if (!ocFull) begin
            for (int k = 0; k < numWarps; k++) begin
                rrIdx = (int'(rrPtr) + k) % numWarps;
                if (!rrFound && issueReq[rrIdx]) begin
                    rrFound = 1'b1;
                    issueGrant[rrIdx] = 1'b1;
                    grantIdx = warpIdW'(rrIdx);
                end
            end
        end
    end

    // pointer moves one past the warp just granted
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rrPtr <= '0;
        end else if (rrFound) begin
            if (grantIdx == warpIdW'(numWarps - 1))
                rrPtr <= '0;
            else
                rrPtr <= grantIdx + 1'b1;
        end
    end

    //////////////////////////////
    // exit grant
    //////////////////////////////

    // lowest set bit of the request vector
    assign exitGrant = exitReq & (~exitReq + 1'b1);

endmodule

// ==== warpInstrBuffer.sv ====
`timescale 1ns/1ps

module warpInstrBuffer (
    input  logic clk,
    input  logic arstN,

    // decode port 0
    input  logic decValid0,
    input  logic [instrBufferPkg::instrW-1:0] dec0Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec0Src1, dec0Src2, dec0Dst,
    input  logic dec0Src1Valid, dec0Src2Valid,
    input  instrBufferPkg::aluOpE dec0AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec0Imm,
    input  logic dec0ImmValid, dec0RegWrite, dec0MemWrite, dec0MemRead,
    input  logic dec0Shared, dec0Beq, dec0Blt, dec0Exit,

    // decode port 1
    input  logic decValid1,
    input  logic [instrBufferPkg::instrW-1:0] dec1Instr,
    input  logic [instrBufferPkg::regIdW-1:0] dec1Src1, dec1Src2, dec1Dst,
    input  logic dec1Src1Valid, dec1Src2Valid,
    input  instrBufferPkg::aluOpE dec1AluOp,
    input  logic [instrBufferPkg::immW-1:0] dec1Imm,
    input  logic dec1ImmValid, dec1RegWrite, dec1MemWrite, dec1MemRead,
    input  logic dec1Shared, dec1Beq, dec1Blt, dec1Exit,

    // flush from the SIMT stack
    input  logic dropInstr,

    // scoreboard status of the head
    input  logic scbFull,
    input  logic scbDependent,

    // arbiter
    input  logic issueGrant,
    input  logic exitGrant,
    output logic fetchReq,
    output logic issueReq,
    output logic exitReq,

    // head entry
    output logic [instrBufferPkg::regIdW-1:0] headSrc1, headSrc2, headDst,
    output logic headSrc1Valid, headSrc2Valid, headDstValid,
    output logic [instrBufferPkg::instrW-1:0] headInstr,
    output instrBufferPkg::aluOpE headAluOp,
    output logic [instrBufferPkg::immW-1:0] headImm,
    output logic headImmValid, headMemWrite, headMemRead,
    output logic headShared, headBeq, headBlt
);
    import instrBufferPkg::*;

    // ten single-bit flags per entry
    localparam int entryW = instrW + 3 * regIdW + $bits(aluOpE) + immW + 10;

    logic [entryW-1:0] entryMem [2];
    logic [entryW-1:0] dec0Entry;
    logic [entryW-1:0] dec1Entry;
    logic headIdx;
    logic [1:0] count;
    logic [1:0] nextCount;
    logic [1:0] space;
    logic headValid;
    logic headExit;
    logic [$bits(aluOpE)-1:0] headAluOpRaw;
    logic rawSrc1Valid;
    logic rawSrc2Valid;
    logic rawRegWrite;
    logic pop;
    logic wr0;
    logic wr1;
    logic slot0;
    logic slot1;

    assign dec0Entry = {dec0Instr, dec0Src1, dec0Src2, dec0Dst, dec0Src1Valid, dec0Src2Valid,
                        dec0AluOp, dec0Imm, dec0ImmValid, dec0RegWrite, dec0MemWrite,
                        dec0MemRead, dec0Shared, dec0Beq, dec0Blt, dec0Exit};
    assign dec1Entry = {dec1Instr, dec1Src1, dec1Src2, dec1Dst, dec1Src1Valid, dec1Src2Valid,
                        dec1AluOp, dec1Imm, dec1ImmValid, dec1RegWrite, dec1MemWrite,
                        dec1MemRead, dec1Shared, dec1Beq, dec1Blt, dec1Exit};

    //////////////////////////////
    // queue pointers
    //////////////////////////////

    assign headValid = count != 2'd0;
    assign pop = (issueGrant | exitGrant) & headValid;

    // room left once this cycle's pop is taken out
    assign space = 2'd2 - count + {1'b0, pop};

    // port 0 takes the first free slot, a flush discards both
    assign wr0 = decValid0 & ~dropInstr & (space != 2'd0);
    assign wr1 = decValid1 & ~dropInstr & (space > {1'b0, wr0});
    assign slot0 = headIdx ^ count[0];
    assign slot1 = slot0 ^ wr0;

    assign nextCount = dropInstr ? 2'd0
                     : count - {1'b0, pop} + {1'b0, wr0} + {1'b0, wr1};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headIdx <= 1'b0;
            count <= 2'd0;
            fetchReq <= 1'b1;
        end else begin
            headIdx <= dropInstr ? 1'b0 : headIdx ^ pop;
            count <= nextCount;
            // ask for more only once nothing is left or arriving
            fetchReq <= nextCount == 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr0)
            entryMem[slot0] <= dec0Entry;
        if (wr1)
            entryMem[slot1] <= dec1Entry;
    end

    //////////////////////////////
    // head and requests
    //////////////////////////////

    assign {headInstr, headSrc1, headSrc2, headDst, rawSrc1Valid, rawSrc2Valid, headAluOpRaw,
            headImm, headImmValid, rawRegWrite, headMemWrite, headMemRead, headShared,
            headBeq, headBlt, headExit} = entryMem[headIdx];
    assign headAluOp = aluOpE'(headAluOpRaw);

    // scoreboard only sees operands of a live head
    assign headSrc1Valid = rawSrc1Valid & headValid;
    assign headSrc2Valid = rawSrc2Valid & headValid;
    assign headDstValid = rawRegWrite & headValid;

    assign issueReq = headValid & ~headExit & ~scbDependent & ~scbFull;
    assign exitReq = headValid & headExit;

endmodule

// ==== instrBufferPkg.sv ====
package instrBufferPkg;

    //////////////////////////////
    // decoded instruction fields
    //////////////////////////////

    // raw instruction word
    localparam int instrW = 32;

    // register index, 32 architectural registers
    localparam int regIdW = 5;

    // immediate operand
    localparam int immW = 16;

    // alu operation carried with each decoded instruction
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluSub = 4'h1,
        aluAnd = 4'h2,
        aluOr  = 4'h3,
        aluXor = 4'h4,
        aluShl = 4'h5,
        aluShr = 4'h6,
        aluMul = 4'h7,
        aluMov = 4'h8,
        // set if less than
        aluSlt = 4'h9
    } aluOpE;

endpackage
